// ==== source/int_pipe_pkg.sv ====
// Shared widths, instruction encodings, ALU operation enumeration and instruction union
package int_pipe_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data path width
  localparam int XLEN   = 32;
  // Register address width
  localparam int REG_AW = 5;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;

  // Funct3 per operation, SUB shares the ADD code
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // Funct7 that turns ADD into SUB
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // One instruction word, seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r;
    struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i;
  } insn_u;

  // ADDI x0,x0,0
  localparam insn_u INSN_NOP = 32'h0000_0013;

endpackage

// ==== source/int_decode.sv ====
// Instruction decoder for the supported R-type and I-type integer operations
`timescale 1ns/10ps

module int_decode import int_pipe_pkg::*; (
  input  insn_u             insn_i,
  output logic [REG_AW-1:0] rs1_o,
  output logic [REG_AW-1:0] rs2_o,
  output logic [REG_AW-1:0] rd_o,
  output logic [XLEN-1:0]   imm_o,
  output logic              use_imm_o,
  output alu_op_e           alu_op_o,
  output logic              legal_o
);

  // Opcode sits in the same place in both views
  always_comb begin
    // Bubble defaults
    rs1_o     = '0;
    rs2_o     = '0;
    rd_o      = '0;
    imm_o     = '0;
    use_imm_o = 1'b0;
    alu_op_o  = ALU_ADD;
    legal_o   = 1'b0;

    case (insn_i.r.opcode)
      ////////////////////////////////////////
      // Register-register
      ////////////////////////////////////////
      OP_REG: begin
        rs1_o = insn_i.r.rs1;
        rs2_o = insn_i.r.rs2;
        rd_o  = insn_i.r.rd;
        case (insn_i.r.funct3)
          F3_ADD: begin
            // Funct7 picks ADD or SUB, anything else is illegal
            if (insn_i.r.funct7 == F7_SUB) begin
              alu_op_o = ALU_SUB;
              legal_o  = 1'b1;
            end else begin
              alu_op_o = ALU_ADD;
              legal_o  = (insn_i.r.funct7 == 7'b0);
            end
          end
          F3_SLT: begin
            alu_op_o = ALU_SLT;
            legal_o  = (insn_i.r.funct7 == 7'b0);
          end
          F3_XOR: begin
            alu_op_o = ALU_XOR;
            legal_o  = (insn_i.r.funct7 == 7'b0);
          end
          F3_OR: begin
            alu_op_o = ALU_OR;
            legal_o  = (insn_i.r.funct7 == 7'b0);
          end
          F3_AND: begin
            alu_op_o = ALU_AND;
            legal_o  = (insn_i.r.funct7 == 7'b0);
          end
          default: legal_o = 1'b0;
        endcase
      end

      ////////////////////////////////////////
      // Register-immediate
      ////////////////////////////////////////
      OP_IMM: begin
        // No second source, rs2 stays zero so nothing is forwarded
        rs1_o     = insn_i.i.rs1;
        rd_o      = insn_i.i.rd;
        imm_o     = {{(XLEN-12){insn_i.i.imm12[11]}}, insn_i.i.imm12};
        use_imm_o = 1'b1;
        legal_o   = 1'b1;
        case (insn_i.i.funct3)
          F3_ADD:  alu_op_o = ALU_ADD;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          // SLTI and shifts are not part of the slice
          default: legal_o  = 1'b0;
        endcase
      end

      default: legal_o = 1'b0;
    endcase
  end

endmodule

// ==== source/int_regfile.sv ====
// Integer register file, 32 x 32, two registered read ports, one write port, x0 tied to zero
`timescale 1ns/10ps

module int_regfile import int_pipe_pkg::*; (
  input  logic              clk_i,
  input  logic [REG_AW-1:0] raddr1_i,
  input  logic [REG_AW-1:0] raddr2_i,
  output logic [XLEN-1:0]   rdata1_o,
  output logic [XLEN-1:0]   rdata2_o,
  input  logic              we_i,
  input  logic [REG_AW-1:0] waddr_i,
  input  logic [XLEN-1:0]   wdata_i
);

  // x1 to x31 only, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Writes to x0 are dropped
  always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Registered read, same-edge write is not seen (old data)
  always_ff @(posedge clk_i) begin
    rdata1_o <= (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    rdata2_o <= (raddr2_i == '0) ? '0 : regs_q[raddr2_i];
  end

endmodule

// ==== source/int_bypass.sv ====
// Operand forwarding from the WB and DWB stages onto the register file read data
`timescale 1ns/10ps

module int_bypass import int_pipe_pkg::*; (
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  input  logic [XLEN-1:0]   rf_data1_i,
  input  logic [XLEN-1:0]   rf_data2_i,
  input  logic              wb_valid_i,
  input  logic [REG_AW-1:0] wb_rd_i,
  input  logic [XLEN-1:0]   wb_data_i,
  input  logic              dwb_valid_i,
  input  logic [REG_AW-1:0] dwb_rd_i,
  input  logic [XLEN-1:0]   dwb_data_i,
  output logic [XLEN-1:0]   op1_o,
  output logic [XLEN-1:0]   op2_o
);

  // One operand, WB wins over DWB, DWB over the register file
  function automatic logic [XLEN-1:0] pick (
    input logic [REG_AW-1:0] rs,
    input logic [XLEN-1:0]   rf_data
  );
    logic [XLEN-1:0] val;
    val = rf_data;
    // x0 reads zero from the file and is never forwarded
    if (rs != '0) begin
      if (wb_valid_i && (wb_rd_i == rs)) begin
        val = wb_data_i;
      end else if (dwb_valid_i && (dwb_rd_i == rs)) begin
        // Covers the write that the file read missed at the same edge
        val = dwb_data_i;
      end
    end
    return val;
  endfunction

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////

  always_comb begin
    op1_o = pick(rs1_i, rf_data1_i);
    op2_o = pick(rs2_i, rf_data2_i);
  end

endmodule

// ==== source/int_alu.sv ====
// Combinational integer ALU for add, sub, and, or, xor and signed set-less-than
`timescale 1ns/10ps

module int_alu import int_pipe_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] res_o
);

  // Signed compare result
  logic lt;

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  // Both operands taken as two's complement
  assign lt = ($signed(a_i) < $signed(b_i));

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD: res_o = a_i + b_i;
      ALU_SUB: res_o = a_i - b_i;
      ALU_AND: res_o = a_i & b_i;
      ALU_OR:  res_o = a_i | b_i;
      ALU_XOR: res_o = a_i ^ b_i;
      // 1 or 0 in the low bit
      ALU_SLT: res_o = {{(XLEN-1){1'b0}}, lt};
      default: res_o = '0;
    endcase
  end

endmodule

// ==== source/int_dwb.sv ====
// Delayed writeback stage, holds the last written rd, valid and result one more cycle
`timescale 1ns/10ps

module int_dwb import int_pipe_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wb_valid_i,
  input  logic [REG_AW-1:0] wb_rd_i,
  input  logic [XLEN-1:0]   wb_data_i,
  output logic              dwb_valid_o,
  output logic [REG_AW-1:0] dwb_rd_o,
  output logic [XLEN-1:0]   dwb_data_o
);

  // Valid and destination follow WB every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dwb_valid_o <= 1'b0;
      dwb_rd_o    <= '0;
    end else begin
      dwb_valid_o <= wb_valid_i;
      dwb_rd_o    <= wb_rd_i;
    end
  end

  // Result keeps the last value actually written
  always_ff @(posedge clk_i) begin
    if (wb_valid_i) dwb_data_o <= wb_data_i;
  end

endmodule

// ==== source/int_pipe_top.sv ====
// Integer execute slice top, ID/EX and EX/WB registers with decode, regfile, bypass, ALU, DWB
`timescale 1ns/10ps

module int_pipe_top import int_pipe_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              insn_valid_i,
  input  logic [XLEN-1:0]   insn_i,
  output logic              wb_valid_o,
  output logic [REG_AW-1:0] wb_rd_o,
  output logic [XLEN-1:0]   wb_data_o
);

  // ID outputs
  logic [REG_AW-1:0] id_rs1, id_rs2, id_rd;
  logic [XLEN-1:0]   id_imm;
  logic              id_use_imm, id_legal;
  alu_op_e           id_alu_op;
  // ID/EX register
  logic              ex_valid_q, ex_use_imm_q;
  logic [REG_AW-1:0] ex_rs1_q, ex_rs2_q, ex_rd_q;
  logic [XLEN-1:0]   ex_imm_q;
  alu_op_e           ex_alu_op_q;
  // EX data path
  logic [XLEN-1:0]   rf_data1, rf_data2, op1, op2, ex_res;
  // DWB stage
  logic              dwb_valid;
  logic [REG_AW-1:0] dwb_rd;
  logic [XLEN-1:0]   dwb_data;

  ////////////////////////////////////////
  // ID
  ////////////////////////////////////////

  int_decode u_decode (
    .insn_i (insn_i), .rs1_o (id_rs1), .rs2_o (id_rs2), .rd_o (id_rd), .imm_o (id_imm),
    .use_imm_o (id_use_imm), .alu_op_o (id_alu_op), .legal_o (id_legal)
  );

  // Read addresses sampled at the strobe edge, write from WB
  int_regfile u_regfile (
    .clk_i (clk_i), .raddr1_i (id_rs1), .raddr2_i (id_rs2),
    .rdata1_o (rf_data1), .rdata2_o (rf_data2),
    .we_i (wb_valid_o), .waddr_i (wb_rd_o), .wdata_i (wb_data_o)
  );

  // Illegal words turn into a bubble here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
      ex_rd_q    <= INSN_NOP.i.rd;
      ex_rs1_q   <= INSN_NOP.i.rs1;
      ex_rs2_q   <= '0;
    end else begin
      ex_valid_q <= insn_valid_i & id_legal;
      if (insn_valid_i) begin
        ex_rd_q  <= id_rd;
        ex_rs1_q <= id_rs1;
        ex_rs2_q <= id_rs2;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insn_valid_i) begin
      ex_imm_q     <= id_imm;
      ex_use_imm_q <= id_use_imm;
      ex_alu_op_q  <= id_alu_op;
    end
  end

  ////////////////////////////////////////
  // EX
  ////////////////////////////////////////

  int_bypass u_bypass (
    .rs1_i (ex_rs1_q), .rs2_i (ex_rs2_q), .rf_data1_i (rf_data1), .rf_data2_i (rf_data2),
    .wb_valid_i (wb_valid_o), .wb_rd_i (wb_rd_o), .wb_data_i (wb_data_o),
    .dwb_valid_i (dwb_valid), .dwb_rd_i (dwb_rd), .dwb_data_i (dwb_data),
    .op1_o (op1), .op2_o (op2)
  );

  // I-type takes the immediate as second operand
  int_alu u_alu (
    .op_i (ex_alu_op_q), .a_i (op1), .b_i (ex_use_imm_q ? ex_imm_q : op2), .res_o (ex_res)
  );

  ////////////////////////////////////////
  // WB and DWB
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_o <= 1'b0;
      wb_rd_o    <= INSN_NOP.i.rd;
    end else begin
      wb_valid_o <= ex_valid_q;
      if (ex_valid_q) wb_rd_o <= ex_rd_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_q) wb_data_o <= ex_res;
  end

  int_dwb u_dwb (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .wb_valid_i (wb_valid_o), .wb_rd_i (wb_rd_o), .wb_data_i (wb_data_o),
    .dwb_valid_o (dwb_valid), .dwb_rd_o (dwb_rd), .dwb_data_o (dwb_data)
  );

endmodule

// ==== verif/int_pipe_chk.sv ====
// Concurrent assertions on the writeback timing of the integer execute slice
`timescale 1ns/10ps

module int_pipe_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic insn_valid_i,
  input logic legal_i,
  input logic wb_valid_i
);

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  // No writeback while reset is held
  a_reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !wb_valid_i)
    else $error("Writeback strobe seen during reset");

  ////////////////////////////////////////
  // Latency
  ////////////////////////////////////////

  // Fixed two-cycle latency for every legal strobe
  a_legal_wb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_valid_i && legal_i |-> ##2 wb_valid_i)
    else $error("Legal instruction gave no writeback two cycles later");

  // Every writeback traces back to a legal strobe
  a_no_stray: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_i |-> $past(insn_valid_i && legal_i, 2))
    else $error("Writeback without a legal strobe two cycles earlier");

endmodule

// ==== verif/int_pipe_tb.sv ====
// Testbench with stimulus table, shadow register model, LCG gaps, writeback monitor, watchdog
`timescale 1ns/10ps

module int_pipe_tb import int_pipe_pkg::*; ();

  localparam int ROWS     = 24;
  localparam int MAX_GAP  = 3;
  localparam int WDOG_CYC = ROWS * (MAX_GAP + 4) + 40;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              insn_valid_i;
  logic [XLEN-1:0]   insn_i;
  logic              wb_valid_o;
  logic [REG_AW-1:0] wb_rd_o;
  logic [XLEN-1:0]   wb_data_o;

  // Table columns with a gap of -1 for an LCG choice
  string             row_name  [ROWS];
  logic [XLEN-1:0]   row_insn  [ROWS];
  int                row_gap   [ROWS];
  logic [REG_AW-1:0] row_rd    [ROWS];
  logic [XLEN-1:0]   row_val   [ROWS];
  // Model results per row
  bit                mdl_legal [ROWS];
  logic [REG_AW-1:0] mdl_rd    [ROWS];
  logic [XLEN-1:0]   mdl_val   [ROWS];
  logic [XLEN-1:0]   shadow    [32];
  // Rows still waiting for their writeback
  int                exp_q [$];
  int                n_rows  = 0;
  int                n_pass  = 0;
  int                n_fail  = 0;
  int                n_stray = 0;
  logic [31:0]       lcg_state = 32'hfa426d6b;

  int_pipe_top dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .insn_valid_i (insn_valid_i), .insn_i (insn_i),
    .wb_valid_o (wb_valid_o), .wb_rd_o (wb_rd_o), .wb_data_o (wb_data_o)
  );

  bind int_pipe_top int_pipe_chk u_chk (
    .clk_i (clk_i), .rst_ni (rst_ni), .insn_valid_i (insn_valid_i),
    .legal_i (id_legal), .wb_valid_i (wb_valid_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Idle cycles 0 to 3 from the top bits
  function automatic int lcg_gap();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:30]);
  endfunction

  function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
    insn_u w;
    w.r = '{f7, rs2[REG_AW-1:0], rs1[REG_AW-1:0], f3, rd[REG_AW-1:0], OP_REG};
    return w;
  endfunction

  function automatic logic [XLEN-1:0] enc_i(input int imm, input logic [2:0] f3,
                                            input int rd, input int rs1);
    insn_u w;
    w.i = '{imm[11:0], rs1[REG_AW-1:0], f3, rd[REG_AW-1:0], OP_IMM};
    return w;
  endfunction

  task automatic add_row(input string n, input logic [XLEN-1:0] w, input int g,
                         input int rd, input logic [XLEN-1:0] v);
    row_name[n_rows] = n;
    row_insn[n_rows] = w;
    row_gap[n_rows]  = g;
    row_rd[n_rows]   = rd[REG_AW-1:0];
    row_val[n_rows]  = v;
    n_rows++;
  endtask

  // ISA rules applied to the shadow registers
  task automatic model_exec(input insn_u w, output bit legal, output logic [REG_AW-1:0] rd,
                            output logic [XLEN-1:0] val);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a     = shadow[w.r.rs1];
    b     = (w.r.opcode == OP_REG) ? shadow[w.r.rs2] : {{20{w.i.imm12[11]}}, w.i.imm12};
    rd    = w.r.rd;
    val   = '0;
    legal = (w.r.opcode == OP_IMM) || (w.r.opcode == OP_REG &&
            (w.r.funct7 == 7'b0 || (w.r.funct7 == F7_SUB && w.r.funct3 == F3_ADD)));
    case (w.r.funct3)
      F3_ADD:  val = (w.r.opcode == OP_REG && w.r.funct7 == F7_SUB) ? a - b : a + b;
      F3_AND:  val = a & b;
      F3_OR:   val = a | b;
      F3_XOR:  val = a ^ b;
      // SLTI is not in the slice
      F3_SLT:  begin
        val   = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        legal = legal && (w.r.opcode == OP_REG);
      end
      default: legal = 1'b0;
    endcase
    if (legal && rd != '0) shadow[rd] = val;
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    add_row("addi_pos",   enc_i(100, F3_ADD, 1, 0),           -1, 1,  32'h0000_0064);
    add_row("addi_neg",   enc_i(-7, F3_ADD, 2, 0),            -1, 2,  32'hffff_fff9);
    add_row("add",        enc_r(7'b0, F3_ADD, 3, 1, 2),       -1, 3,  32'h0000_005d);
    add_row("sub",        enc_r(F7_SUB, F3_ADD, 4, 1, 2),     -1, 4,  32'h0000_006b);
    add_row("and",        enc_r(7'b0, F3_AND, 5, 1, 2),       -1, 5,  32'h0000_0060);
    add_row("or",         enc_r(7'b0, F3_OR, 6, 1, 2),        -1, 6,  32'hffff_fffd);
    add_row("xor",        enc_r(7'b0, F3_XOR, 7, 1, 2),       -1, 7,  32'hffff_ff9d);
    add_row("slt_neg",    enc_r(7'b0, F3_SLT, 8, 2, 1),       -1, 8,  32'h0000_0001);
    add_row("slt_pos",    enc_r(7'b0, F3_SLT, 9, 1, 2),       -1, 9,  32'h0000_0000);
    add_row("andi_neg",   enc_i(-16, F3_AND, 10, 7),          -1, 10, 32'hffff_ff90);
    add_row("ori",        enc_i(240, F3_OR, 11, 1),           -1, 11, 32'h0000_00f4);
    add_row("xori_neg",   enc_i(-1, F3_XOR, 12, 1),           -1, 12, 32'hffff_ff9b);
    // Back-to-back rows at distance 1, 2 and 3 from fwd_base
    add_row("fwd_base",   enc_i(5, F3_ADD, 13, 0),            0,  13, 32'h0000_0005);
    add_row("fwd_wb",     enc_i(3, F3_ADD, 14, 13),           0,  14, 32'h0000_0008);
    add_row("fwd_dwb",    enc_i(10, F3_ADD, 15, 13),          0,  15, 32'h0000_000f);
    add_row("fwd_rf",     enc_r(7'b0, F3_ADD, 16, 13, 14),    0,  16, 32'h0000_000d);
    add_row("x0_write",   enc_i(7, F3_ADD, 0, 13),            0,  0,  32'h0000_000c);
    add_row("x0_read",    enc_r(7'b0, F3_ADD, 17, 0, 13),     0,  17, 32'h0000_0005);
    // LUI opcode with rd x18 gives no writeback
    add_row("bad_opcode", 32'h0000_0937,                      0,  18, 32'h0000_0000);
    add_row("after_bad",  enc_i(1, F3_ADD, 18, 17),           -1, 18, 32'h0000_0006);
    add_row("rnd_sub",    enc_r(F7_SUB, F3_ADD, 20, 18, 16),  -1, 20, 32'hffff_fff9);
    add_row("rnd_slt",    enc_r(7'b0, F3_SLT, 21, 20, 18),    -1, 21, 32'h0000_0001);
    add_row("rnd_xori",   enc_i(2047, F3_XOR, 22, 20),        -1, 22, 32'hffff_f806);
    add_row("rnd_or",     enc_r(7'b0, F3_OR, 23, 21, 22),     -1, 23, 32'hffff_f807);
  endtask

  // Table checked against the model and the expected writeback order built
  task automatic run_model();
    foreach (shadow[r]) shadow[r] = '0;
    for (int i = 0; i < ROWS; i++) begin
      model_exec(row_insn[i], mdl_legal[i], mdl_rd[i], mdl_val[i]);
      if (mdl_legal[i]) exp_q.push_back(i);
      if (mdl_legal[i] && (mdl_rd[i] != row_rd[i] || mdl_val[i] != row_val[i])) begin
        $display("ERR %s table expected x%0d=%h model x%0d=%h", row_name[i], row_rd[i],
                 row_val[i], mdl_rd[i], mdl_val[i]);
        n_fail++;
      end
    end
  endtask

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    int idx;
    if (rst_ni && wb_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Writeback to x%0d with no instruction left to expect", wb_rd_o);
        n_stray++;
        n_fail++;
      end else begin
        idx = exp_q.pop_front();
        if (wb_rd_o != mdl_rd[idx]) begin
          $display("ERR %s rd expected %0d actual %0d", row_name[idx], mdl_rd[idx], wb_rd_o);
          n_fail++;
        end else if (wb_data_o != mdl_val[idx]) begin
          $display("ERR %s data expected %h actual %h", row_name[idx], mdl_val[idx],
                   wb_data_o);
          n_fail++;
        end else begin
          $display("OK %s x%0d=%h", row_name[idx], wb_rd_o, wb_data_o);
          n_pass++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Driver and end of run
  ////////////////////////////////////////

  initial begin
    int g;
    rst_ni       = 1'b0;
    insn_valid_i = 1'b0;
    insn_i       = INSN_NOP;
    build_table();
    run_model();
    repeat (16) @(posedge clk_i);
    #0.5 rst_ni = 1'b1;
    for (int i = 0; i < ROWS; i++) begin
      @(posedge clk_i);
      #0.5;
      insn_valid_i = 1'b1;
      insn_i       = row_insn[i];
      g = (row_gap[i] < 0) ? lcg_gap() : row_gap[i];
      repeat (g) begin
        @(posedge clk_i);
        #0.5 insn_valid_i = 1'b0;
      end
    end
    @(posedge clk_i);
    #0.5 insn_valid_i = 1'b0;
    // Wait for the queue to drain and for any late writeback of a bubble
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (MAX_GAP + 2) @(posedge clk_i);
    for (int i = 0; i < ROWS; i++) begin
      if (!mdl_legal[i] && n_stray == 0) begin
        $display("OK %s no writeback", row_name[i]);
        n_pass++;
      end else if (!mdl_legal[i]) begin
        $display("Bubble %s still produced a writeback", row_name[i]);
        n_fail++;
      end
    end
    $display("Tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WDOG_CYC * 4);
    $display("Timeout, writebacks still missing after %0d cycles", WDOG_CYC);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== int_pipe.f ====
source/int_pipe_pkg.sv
source/int_decode.sv
source/int_regfile.sv
source/int_bypass.sv
source/int_alu.sv
source/int_dwb.sv
source/int_pipe_top.sv
verif/int_pipe_chk.sv
verif/int_pipe_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = int_pipe_tb
FILELIST   = int_pipe.f
OBJ_DIR    = obj_dir
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
